/* common/replay_params.svh */
// Width, depth and threshold macros for the replay engine, included by the package and the RTL
`ifndef REPLAY_PARAMS_SVH
`define REPLAY_PARAMS_SVH

// Byte lanes in one store word
`define REPLAY_DATA_BYTES 8
// User sideband carried in the header
`define REPLAY_TUSER_WIDTH 32
// Gap field in the header, also the timer width
`define REPLAY_GAP_WIDTH 16
// Store depth in words
`define REPLAY_FIFO_DEPTH 16
// Occupancy that raises prog_full
`define REPLAY_PROG_FULL 12

`endif

/* common/replay_pkg.sv */
// Shared types for the replay engine, referenced by scoped name from the RTL and testbench
`include "replay_params.svh"

package replay_pkg;

  // One byte lane as stored, strobe above data
  typedef struct packed {
    logic       strb;
    logic [7:0] data;
  } lane_t;

  // Store word, lane 0 in the low bits
  // As a header: tuser in the low bits, gap just above it
  typedef lane_t [`REPLAY_DATA_BYTES-1:0] fifo_word_t;

  // Outgoing stream beat
  typedef struct packed {
    logic [`REPLAY_DATA_BYTES*8-1:0]  tdata;
    logic [`REPLAY_DATA_BYTES-1:0]    tstrb;
    logic [`REPLAY_TUSER_WIDTH-1:0]   tuser;
    logic                             tlast;
  } axis_beat_t;

  // Controller states
  typedef enum logic [1:0] {
    rd_header,
    wait_gap,
    rd_body
  } replay_state_e;

endpackage

/* design/replay_fifo.sv */
// Synchronous first-word-fall-through packet store that host logic writes and the controller reads
`timescale 1ns/100ps
`include "replay_params.svh"

module replay_fifo (
  input  logic                   axi_aclk,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   wr_en,
  input  replay_pkg::fifo_word_t din,
  input  logic                   rd_en,
  output replay_pkg::fifo_word_t dout,
  output logic                   empty,
  output logic                   full,
  output logic                   prog_full
);

  localparam int depth = `REPLAY_FIFO_DEPTH;
  localparam int ptr_width = $clog2(depth);
  localparam int count_width = $clog2(depth + 1);

  // Storage array of packet words
  replay_pkg::fifo_word_t mem [depth];

  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic                   wr_ok;
  logic                   rd_ok;

  // Writes while full are dropped
  assign wr_ok = wr_en && !full;
  assign rd_ok = rd_en && !empty;

  always_ff @(posedge axi_aclk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge axi_aclk) begin
    if (reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Read and write together leave count alone
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head word always visible
  assign dout = mem[rd_ptr];

  // Flags straight from occupancy
  assign empty     = (count == '0);
  assign full      = (count == count_width'(depth));
  assign prog_full = (count >= count_width'(`REPLAY_PROG_FULL));

endmodule

/* replay_engine/gap_timer.sv */
// Inter-packet gap down-counter, loaded by the controller from each header
`timescale 1ns/100ps
`include "replay_params.svh"

module gap_timer (
  input  logic                         axi_aclk,
  input  logic                         reset,
  input  logic                         clear,
  input  logic                         load,
  input  logic [`REPLAY_GAP_WIDTH-1:0] gap,
  output logic                         done
);

  logic [`REPLAY_GAP_WIDTH-1:0] count;

  always_ff @(posedge axi_aclk) begin
    if (reset || clear) begin
      count <= '0;
    end else if (load) begin
      // New gap from header
      count <= gap;
    end else if (count != '0) begin
      // Stops at zero
      count <= count - 1'b1;
    end
  end

  // Zero count means the gap is over
  assign done = (count == '0);

endmodule

/* replay_engine/replay_ctrl.sv */
// Replay controller FSM, pops headers, waits out the gap and streams body words as AXI-Stream beats
`timescale 1ns/100ps
`include "replay_params.svh"

module replay_ctrl (
  input  logic                         axi_aclk,
  input  logic                         reset,
  input  logic                         sw_enable,
  input  replay_pkg::fifo_word_t       fifo_dout,
  input  logic                         fifo_empty,
  output logic                         fifo_rd_en,
  output logic                         gap_load,
  output logic [`REPLAY_GAP_WIDTH-1:0] gap_value,
  input  logic                         gap_done,
  output replay_pkg::axis_beat_t       m_axis_beat,
  output logic                         m_axis_tvalid,
  input  logic                         m_axis_tready
);

  replay_pkg::replay_state_e state;
  replay_pkg::replay_state_e next_state;

  logic [`REPLAY_TUSER_WIDTH-1:0]          tuser_q;
  logic [`REPLAY_TUSER_WIDTH-1:0]          tuser_d;
  logic [$bits(replay_pkg::fifo_word_t)-1:0] head_bits;
  logic [`REPLAY_DATA_BYTES*8-1:0]         body_data;
  logic [`REPLAY_DATA_BYTES-1:0]           body_strb;
  logic                                    last_word;

  // Flat view of the head word for header fields
  assign head_bits = fifo_dout;
  assign gap_value = head_bits[`REPLAY_TUSER_WIDTH +: `REPLAY_GAP_WIDTH];

  // Split lanes into data bytes and strobes
  always_comb begin
    for (int i = 0; i < `REPLAY_DATA_BYTES; i++) begin
      body_data[8*i +: 8] = fifo_dout[i].data;
      body_strb[i]        = fifo_dout[i].strb;
    end
  end

  // Any missing strobe marks the final beat
  assign last_word = (body_strb != {`REPLAY_DATA_BYTES{1'b1}});

  // Beat payload follows the head word, held steady under back-pressure
  assign m_axis_beat.tdata = body_data;
  assign m_axis_beat.tstrb = body_strb;
  assign m_axis_beat.tuser = tuser_q;
  assign m_axis_beat.tlast = last_word;

  // Next state and handshake
  always_comb begin
    next_state    = state;
    tuser_d       = tuser_q;
    fifo_rd_en    = 1'b0;
    gap_load      = 1'b0;
    m_axis_tvalid = 1'b0;

    case (state)
      replay_pkg::rd_header: begin
        if (sw_enable && !fifo_empty) begin
          // Header pop, sideband captured now
          fifo_rd_en = 1'b1;
          tuser_d    = head_bits[`REPLAY_TUSER_WIDTH-1:0];
          if (gap_value != '0) begin
            gap_load   = 1'b1;
            next_state = replay_pkg::wait_gap;
          end else begin
            next_state = replay_pkg::rd_body;
          end
        end
      end

      replay_pkg::wait_gap: begin
        if (gap_done) begin
          next_state = replay_pkg::rd_body;
        end
      end

      replay_pkg::rd_body: begin
        if (sw_enable && !fifo_empty) begin
          m_axis_tvalid = 1'b1;
          // One pop per accepted beat
          if (m_axis_tready) begin
            fifo_rd_en = 1'b1;
            if (last_word) begin
              next_state = replay_pkg::rd_header;
            end
          end
        end
      end

      default: begin
        next_state = replay_pkg::rd_header;
      end
    endcase
  end

  // State and sideband registers, cleared by reset or disable
  always_ff @(posedge axi_aclk) begin
    if (reset || !sw_enable) begin
      state   <= replay_pkg::rd_header;
      tuser_q <= '0;
    end else begin
      state   <= next_state;
      tuser_q <= tuser_d;
    end
  end

endmodule

/* design/replay_top.sv */
// Replay engine top level, host write port in and AXI-Stream master out
`timescale 1ns/100ps
`include "replay_params.svh"

module replay_top (
  input  logic                   axi_aclk,
  input  logic                   reset,
  input  logic                   sw_enable,
  input  logic                   wr_en,
  input  replay_pkg::fifo_word_t din,
  output logic                   fifo_full,
  output logic                   fifo_prog_full,
  output replay_pkg::axis_beat_t m_axis_beat,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready
);

  replay_pkg::fifo_word_t       fifo_dout;
  logic                         fifo_empty;
  logic                         fifo_rd_en;
  logic                         gap_load;
  logic [`REPLAY_GAP_WIDTH-1:0] gap_value;
  logic                         gap_done;
  logic                         sw_clear;

  // Disabled engine flushes store and timer
  assign sw_clear = ~sw_enable;

  replay_fifo i_fifo (
    .axi_aclk  (axi_aclk),
    .reset     (reset),
    .clear     (sw_clear),
    .wr_en     (wr_en),
    .din       (din),
    .rd_en     (fifo_rd_en),
    .dout      (fifo_dout),
    .empty     (fifo_empty),
    .full      (fifo_full),
    .prog_full (fifo_prog_full)
  );

  replay_ctrl i_ctrl (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_enable     (sw_enable),
    .fifo_dout     (fifo_dout),
    .fifo_empty    (fifo_empty),
    .fifo_rd_en    (fifo_rd_en),
    .gap_load      (gap_load),
    .gap_value     (gap_value),
    .gap_done      (gap_done),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  gap_timer i_gap_timer (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .clear    (sw_clear),
    .load     (gap_load),
    .gap      (gap_value),
    .done     (gap_done)
  );

endmodule

/* verif/replay_tests.svh */
// Directed test tasks and their helpers, included inside the replay_tb module
`ifndef REPLAY_TESTS_SVH
`define REPLAY_TESTS_SVH

task automatic report_value(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
  error_count++;
  $display("Fail at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
endtask

task automatic finish_test(input string name, input int errs_before);
  tests_run++;
  $display("Test %s finished with %0d errors", name, error_count - errs_before);
endtask

// Called at a falling edge, returns at the next one
task automatic write_word(input replay_pkg::fifo_word_t w);
  wr_en = 1'b1;
  din   = w;
  @(negedge axi_aclk);
  wr_en = 1'b0;
endtask

// Header layout with tuser low and gap above it
function automatic replay_pkg::fifo_word_t header_word(input logic [31:0] tuser,
                                                       input logic [15:0] gap);
  logic [`REPLAY_DATA_BYTES*9-1:0] bits;
  bits        = '0;
  bits[31:0]  = tuser;
  bits[47:32] = gap;
  return bits;
endfunction

// Random body word with the low nvalid lanes strobed
task automatic push_body(input logic [31:0] tuser, input int nvalid);
  replay_pkg::fifo_word_t w;
  replay_pkg::axis_beat_t b;
  for (int i = 0; i < `REPLAY_DATA_BYTES; i++) begin
    w[i].data         = 8'($random(seed));
    w[i].strb         = (i < nvalid);
    b.tdata[8*i +: 8] = w[i].data;
    b.tstrb[i]        = w[i].strb;
  end
  b.tuser = tuser;
  // Any lane without strobe ends the packet
  b.tlast = (nvalid < `REPLAY_DATA_BYTES);
  write_word(w);
  exp_q.push_back(b);
endtask

// Exact-length packets get a trailing zero-strobe word
task automatic send_packet(input logic [31:0] tuser, input logic [15:0] gap, input int nbytes);
  write_word(header_word(tuser, gap));
  for (int k = 0; k < nbytes / 8; k++) begin
    push_body(tuser, 8);
  end
  push_body(tuser, nbytes % 8);
endtask

task automatic collect_and_compare(input int limit);
  int waited;
  int n;
  waited = 0;
  while (rx_q.size() < exp_q.size() && waited < limit) begin
    @(negedge axi_aclk);
    waited++;
  end
  // Catch surplus beats
  repeat (4) @(negedge axi_aclk);
  if (rx_q.size() != exp_q.size()) begin
    error_count++;
    $display("Wrong number of beats at %0t: expected %0d, received %0d",
             $time, exp_q.size(), rx_q.size());
  end
  n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
  for (int i = 0; i < n; i++) begin
    if (rx_q[i].tdata !== exp_q[i].tdata)
      report_value($sformatf("tdata beat %0d", i), exp_q[i].tdata, rx_q[i].tdata);
    if (rx_q[i].tstrb !== exp_q[i].tstrb)
      report_value($sformatf("tstrb beat %0d", i), exp_q[i].tstrb, rx_q[i].tstrb);
    if (rx_q[i].tuser !== exp_q[i].tuser)
      report_value($sformatf("tuser beat %0d", i), exp_q[i].tuser, rx_q[i].tuser);
    if (rx_q[i].tlast !== exp_q[i].tlast)
      report_value($sformatf("tlast beat %0d", i), exp_q[i].tlast, rx_q[i].tlast);
  end
  rx_q.delete();
  exp_q.delete();
endtask

task automatic test_reset_state();
  int errs;
  errs = error_count;
  m_axis_tready = 1'b1;
  if (m_axis_tvalid !== 1'b0) report_value("m_axis_tvalid", 0, m_axis_tvalid);
  if (fifo_full !== 1'b0) report_value("fifo_full", 0, fifo_full);
  if (fifo_prog_full !== 1'b0) report_value("fifo_prog_full", 0, fifo_prog_full);
  repeat (10) @(negedge axi_aclk);
  if (rx_q.size() != 0) begin
    error_count++;
    $display("Beats came out of an empty store");
  end
  finish_test("reset_state", errs);
endtask

task automatic test_single_packet();
  int errs;
  errs = error_count;
  // Partial final word, then exact length
  send_packet(32'h1234_5678, 16'd0, 21);
  send_packet(32'h9abc_def0, 16'd0, 16);
  collect_and_compare(200);
  finish_test("single_packet", errs);
endtask

task automatic test_back_pressure();
  int errs;
  errs = error_count;
  ready_random = 1'b1;
  send_packet(32'h3000_0001, 16'd0, 20);
  send_packet(32'h3000_0002, 16'd0, 13);
  send_packet(32'h3000_0003, 16'd0, 16);
  collect_and_compare(400);
  ready_random  = 1'b0;
  m_axis_tready = 1'b1;
  finish_test("back_pressure", errs);
endtask

task automatic test_gap();
  int errs;
  int hdr_cycle;
  errs = error_count;
  write_word(header_word(32'h0000_4a11, 16'd20));
  hdr_cycle = cycle_count;
  push_body(32'h0000_4a11, 8);
  push_body(32'h0000_4a11, 8);
  push_body(32'h0000_4a11, 6);
  collect_and_compare(200);
  // Gap of 20 plus the header pop
  if (first_rx_cycle - hdr_cycle < 21) begin
    error_count++;
    $display("First beat only %0d clocks after the header write, gap not honored",
             first_rx_cycle - hdr_cycle);
  end
  finish_test("gap", errs);
endtask

task automatic test_fill_flags();
  int errs;
  errs = error_count;
  m_axis_tready = 1'b0;
  write_word(header_word(32'h5e5e_0005, 16'd2));
  // Let the header pop first
  repeat (2) @(negedge axi_aclk);
  for (int k = 1; k <= 16; k++) begin
    push_body(32'h5e5e_0005, (k == 16) ? 3 : 8);
    if (fifo_prog_full !== (k >= 12)) report_value("fifo_prog_full", k >= 12, fifo_prog_full);
    if (fifo_full !== (k >= 16)) report_value("fifo_full", k >= 16, fifo_full);
  end
  // Full store drops this word, else a stray header would show up
  write_word(header_word(32'hdead_beef, 16'd0));
  if (fifo_full !== 1'b1) report_value("fifo_full", 1, fifo_full);
  m_axis_tready = 1'b1;
  collect_and_compare(200);
  send_packet(32'h5e5e_0006, 16'd0, 10);
  collect_and_compare(200);
  finish_test("fill_flags", errs);
endtask

task automatic test_sw_enable();
  int errs;
  errs = error_count;
  m_axis_tready = 1'b0;
  // Sixteen body words fill the store
  send_packet(32'h6000_0006, 16'd0, 127);
  repeat (2) @(negedge axi_aclk);
  if (fifo_prog_full !== 1'b1) report_value("fifo_prog_full", 1, fifo_prog_full);
  if (fifo_full !== 1'b1) report_value("fifo_full", 1, fifo_full);
  if (m_axis_tvalid !== 1'b1) report_value("m_axis_tvalid", 1, m_axis_tvalid);
  sw_enable = 1'b0;
  @(negedge axi_aclk);
  if (m_axis_tvalid !== 1'b0) report_value("m_axis_tvalid", 0, m_axis_tvalid);
  if (fifo_full !== 1'b0) report_value("fifo_full", 0, fifo_full);
  if (fifo_prog_full !== 1'b0) report_value("fifo_prog_full", 0, fifo_prog_full);
  exp_q.delete();
  sw_enable     = 1'b1;
  m_axis_tready = 1'b1;
  send_packet(32'h6000_0007, 16'd0, 12);
  collect_and_compare(200);
  finish_test("sw_enable", errs);
endtask

`endif

/* verif/replay_tb.sv */
// Testbench top that runs the directed tests in replay_tests.svh against replay_top
`timescale 1ns/100ps
`include "replay_params.svh"

module replay_tb;

  logic                   axi_aclk;
  logic                   reset;
  logic                   sw_enable;
  logic                   wr_en;
  replay_pkg::fifo_word_t din;
  logic                   fifo_full;
  logic                   fifo_prog_full;
  replay_pkg::axis_beat_t m_axis_beat;
  logic                   m_axis_tvalid;
  logic                   m_axis_tready;

  // Expected and received beats
  replay_pkg::axis_beat_t exp_q[$];
  replay_pkg::axis_beat_t rx_q[$];

  integer                 seed = 16039;
  int                     error_count = 0;
  int                     tests_run = 0;
  int                     cycle_count = 0;
  int                     first_rx_cycle = 0;
  logic                   ready_random = 1'b0;
  logic                   held = 1'b0;
  replay_pkg::axis_beat_t held_beat;

  replay_top i_dut (
    .axi_aclk       (axi_aclk),
    .reset          (reset),
    .sw_enable      (sw_enable),
    .wr_en          (wr_en),
    .din            (din),
    .fifo_full      (fifo_full),
    .fifo_prog_full (fifo_prog_full),
    .m_axis_beat    (m_axis_beat),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready)
  );

  // 40 ns period
  always #20 axi_aclk = ~axi_aclk;

  // Random ready pattern for back-pressure
  always @(negedge axi_aclk) begin
    if (ready_random) begin
      m_axis_tready = 1'($random(seed));
    end
  end

  // Stream monitor sampling pre-edge values
  always @(posedge axi_aclk) begin
    cycle_count = cycle_count + 1;
    // Beat stalled last clock must stay put
    if (held && sw_enable && (!m_axis_tvalid || m_axis_beat !== held_beat)) begin
      error_count++;
      $display("Fail at %0t: m_axis_beat under back-pressure expected %h, actual %h (tvalid %b)",
               $time, held_beat, m_axis_beat, m_axis_tvalid);
    end
    if (m_axis_tvalid && m_axis_tready) begin
      if (rx_q.size() == 0) begin
        first_rx_cycle = cycle_count;
      end
      rx_q.push_back(m_axis_beat);
    end
    held      = m_axis_tvalid && !m_axis_tready;
    held_beat = m_axis_beat;
  end

  `include "replay_tests.svh"

  // Watchdog over the whole run, 4000 clock periods
  initial begin
    repeat (4000) @(posedge axi_aclk);
    $display("Timeout: run stopped after 4000 clock periods");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    axi_aclk      = 1'b0;
    reset         = 1'b1;
    sw_enable     = 1'b1;
    wr_en         = 1'b0;
    din           = '0;
    m_axis_tready = 1'b0;
    repeat (16) @(posedge axi_aclk);
    @(negedge axi_aclk);
    reset = 1'b0;
    test_reset_state();
    test_single_packet();
    test_back_pressure();
    test_gap();
    test_fill_flags();
    test_sw_enable();
    $display("%0d tests run, %0d errors", tests_run, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+common
+incdir+verif
common/replay_pkg.sv
design/replay_fifo.sv
replay_engine/gap_timer.sv
replay_engine/replay_ctrl.sv
design/replay_top.sv
verif/replay_tb.sv

/* Bender.yml */
package:
  name: replay_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/replay_pkg.sv
      - design/replay_fifo.sv
      - replay_engine/gap_timer.sv
      - replay_engine/replay_ctrl.sv
      - design/replay_top.sv
  - target: simulation
    include_dirs:
      - common
      - verif
    files:
      - verif/replay_tb.sv
